/* rtl/y86Pkg.sv */
`default_nettype none

package y86Pkg;

  // machine word and field types
  typedef logic [63:0] wordT;
  typedef logic [3:0]  icodeT;
  typedef logic [3:0]  ifunT;
  typedef logic [3:0]  regIdT;
  typedef logic [1:0]  statT;

  // instruction codes, upper nibble of byte 0
  localparam icodeT icHalt   = 4'h0;
  localparam icodeT icNop    = 4'h1;
  localparam icodeT icRrmovq = 4'h2;
  localparam icodeT icIrmovq = 4'h3;
  localparam icodeT icRmmovq = 4'h4;
  localparam icodeT icMrmovq = 4'h5;
  localparam icodeT icOpq    = 4'h6;
  localparam icodeT icJxx    = 4'h7;
  localparam icodeT icCall   = 4'h8;
  localparam icodeT icRet    = 4'h9;
  localparam icodeT icPushq  = 4'hA;
  localparam icodeT icPopq   = 4'hB;

  // alu functions for OPq
  localparam ifunT aluAdd = 4'h0;
  localparam ifunT aluSub = 4'h1;
  localparam ifunT aluAnd = 4'h2;
  localparam ifunT aluXor = 4'h3;

  // branch / conditional move conditions
  localparam ifunT cAlways = 4'h0;
  localparam ifunT cLe     = 4'h1;
  localparam ifunT cL      = 4'h2;
  localparam ifunT cE      = 4'h3;
  localparam ifunT cNe     = 4'h4;
  localparam ifunT cGe     = 4'h5;
  localparam ifunT cG      = 4'h6;

  // register ids
  localparam regIdT regRsp  = 4'h4;
  localparam regIdT regNone = 4'hF;

  // core status
  localparam statT statAok = 2'd0;
  localparam statT statHlt = 2'd1;
  localparam statT statAdr = 2'd2;
  localparam statT statIns = 2'd3;

endpackage

`default_nettype wire

/* rtl/fetchStage.sv */
`default_nettype none

module fetchStage
  import y86Pkg::*;
#(
  parameter int imemBytes = 256
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       progWe,
  input  wordT       progAddr,
  input  logic [7:0] progData,
  input  wordT       pc,
  output icodeT      icode,
  output ifunT       ifun,
  output regIdT      rA,
  output regIdT      rB,
  output wordT       valC,
  output wordT       valP,
  output logic       instrValid,
  output logic       imemError
);
  localparam int addrW = $clog2(imemBytes);

  logic [7:0] imem [imemBytes];
  logic [7:0] instrBytes [10];
  logic       needRegs;
  logic       needValC;
  wordT       instrLen;

  // program load, only honoured while the core sits in reset
  always_ff @(posedge clk) begin
    if (rst && progWe && (progAddr < wordT'(imemBytes))) begin
      imem[progAddr[addrW-1:0]] <= progData;
    end
  end

  // grab ten bytes from pc, zero past the end of memory
  always_comb begin
    wordT byteAddr;
    for (int k = 0; k < 10; k++) begin
      byteAddr = pc + wordT'(k);
      instrBytes[k] = (byteAddr < wordT'(imemBytes)) ? imem[byteAddr[addrW-1:0]] : 8'h00;
    end
  end

  assign icode = instrBytes[0][7:4];
  assign ifun  = instrBytes[0][3:0];

  // which optional fields follow the opcode byte
  assign needRegs = icode inside {icRrmovq, icIrmovq, icRmmovq, icMrmovq,
                                  icOpq, icPushq, icPopq};
  assign needValC = icode inside {icIrmovq, icRmmovq, icMrmovq, icJxx, icCall};

  assign rA = needRegs ? instrBytes[1][7:4] : regNone;
  assign rB = needRegs ? instrBytes[1][3:0] : regNone;

  // constant is little endian, shifted by one when a register byte exists
  always_comb begin
    for (int k = 0; k < 8; k++) begin
      valC[8*k +: 8] = needRegs ? instrBytes[k+2] : instrBytes[k+1];
    end
  end

  // length is 1, 2, 9 or 10 bytes
  assign instrLen = wordT'(1) + wordT'(needRegs) + (needValC ? wordT'(8) : wordT'(0));
  assign valP     = pc + instrLen;

  // last needed byte must still be inside the array
  assign imemError = pc > (wordT'(imemBytes) - instrLen);

  // function code check per instruction class
  always_comb begin
    case (icode)
      icHalt, icNop, icIrmovq, icRmmovq, icMrmovq,
      icCall, icRet, icPushq, icPopq: instrValid = (ifun == 4'h0);
      icRrmovq, icJxx:                instrValid = (ifun <= cG);
      icOpq:                          instrValid = (ifun <= aluXor);
      default:                        instrValid = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

/* rtl/decodeWriteback.sv */
`default_nettype none

module decodeWriteback
  import y86Pkg::*;
(
  input  logic  clk,
  input  logic  run,
  input  icodeT icode,
  input  regIdT rA,
  input  regIdT rB,
  input  logic  cnd,
  input  wordT  valE,
  input  wordT  valM,
  input  regIdT dbgReg,
  output wordT  valA,
  output wordT  valB,
  output wordT  dbgValue
);
  wordT  regs [15];
  regIdT srcA;
  regIdT srcB;
  regIdT dstE;
  regIdT dstM;
  logic  wrE;
  logic  wrM;

  // source and destination steering by SEQ rules
  always_comb begin
    srcA = regNone;
    srcB = regNone;
    dstE = regNone;
    dstM = regNone;
    case (icode)
      icRrmovq: begin
        srcA = rA;
        // failed cmov drops its write
        dstE = cnd ? rB : regNone;
      end
      icIrmovq: dstE = rB;
      icRmmovq: begin
        srcA = rA;
        srcB = rB;
      end
      icMrmovq: begin
        srcB = rB;
        dstM = rA;
      end
      icOpq: begin
        srcA = rA;
        srcB = rB;
        dstE = rB;
      end
      icCall: begin
        srcB = regRsp;
        dstE = regRsp;
      end
      icPushq: begin
        srcA = rA;
        srcB = regRsp;
        dstE = regRsp;
      end
      icRet, icPopq: begin
        srcA = regRsp;
        srcB = regRsp;
        dstE = regRsp;
        dstM = (icode == icPopq) ? rA : regNone;
      end
      default: ;
    endcase
  end

  // regNone reads as zero
  assign valA     = (srcA == regNone) ? '0 : regs[srcA];
  assign valB     = (srcB == regNone) ? '0 : regs[srcB];
  assign dbgValue = (dbgReg == regNone) ? '0 : regs[dbgReg];

  assign wrE = run && (dstE != regNone);
  assign wrM = run && (dstM != regNone);

  // valM write comes second so popq %rsp keeps the loaded value
  always_ff @(posedge clk) begin
    if (wrE) begin
      regs[dstE] <= valE;
    end
    if (wrM) begin
      regs[dstM] <= valM;
    end
  end

  // memory result lands even against a same-register valE write
  assert property (@(posedge clk) wrM |=> regs[$past(dstM)] == $past(valM));

endmodule

`default_nettype wire

/* rtl/executeStage.sv */
`default_nettype none

module executeStage
  import y86Pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  logic  run,
  input  icodeT icode,
  input  ifunT  ifun,
  input  wordT  valA,
  input  wordT  valB,
  input  wordT  valC,
  output wordT  valE,
  output logic  cnd
);
  wordT aluA;
  wordT aluB;
  ifunT aluFun;
  logic zfNext;
  logic sfNext;
  logic ofNext;
  logic [2:0] cc;
  logic ccWe;
  logic zf;
  logic sf;
  logic of;

  // operand A: register, constant or stack step
  always_comb begin
    case (icode)
      icRrmovq, icOpq:             aluA = valA;
      icIrmovq, icRmmovq, icMrmovq: aluA = valC;
      icCall, icPushq:             aluA = -wordT'(8);
      icRet, icPopq:               aluA = wordT'(8);
      default:                     aluA = '0;
    endcase
  end

  // operand B is valB unless the move only passes A through
  assign aluB = (icode inside {icRmmovq, icMrmovq, icOpq, icCall,
                               icPushq, icRet, icPopq}) ? valB : '0;

  // everything except OPq just adds
  assign aluFun = (icode == icOpq) ? ifun : aluAdd;

  always_comb begin
    ofNext = 1'b0;
    case (aluFun)
      aluSub: begin
        valE   = aluB - aluA;
        ofNext = (aluB[63] != aluA[63]) && (valE[63] != aluB[63]);
      end
      aluAnd: valE = aluB & aluA;
      aluXor: valE = aluB ^ aluA;
      default: begin
        valE   = aluB + aluA;
        ofNext = (aluB[63] == aluA[63]) && (valE[63] != aluA[63]);
      end
    endcase
  end

  assign zfNext = (valE == '0);
  assign sfNext = valE[63];

  // condition codes, set only by a committing OPq
  assign ccWe = run && (icode == icOpq);

  always_ff @(posedge clk) begin
    if (rst) begin
      cc <= 3'b100;
    end else if (ccWe) begin
      cc <= {zfNext, sfNext, ofNext};
    end
  end

  assign {zf, sf, of} = cc;

  // condition from the held codes
  always_comb begin
    case (ifun)
      cAlways: cnd = 1'b1;
      cLe:     cnd = (sf ^ of) | zf;
      cL:      cnd = sf ^ of;
      cE:      cnd = zf;
      cNe:     cnd = !zf;
      cGe:     cnd = !(sf ^ of);
      cG:      cnd = !(sf ^ of) && !zf;
      default: cnd = 1'b0;
    endcase
  end

  // codes move only after reset or a committed OPq
  assert property (@(posedge clk) disable iff (rst)
                   !$past(ccWe) && !$past(rst) |-> $stable(cc));

endmodule

`default_nettype wire

/* rtl/dataMemory.sv */
`default_nettype none

module dataMemory
  import y86Pkg::*;
#(
  parameter int dmemWords = 64
) (
  input  logic  clk,
  input  logic  run,
  input  icodeT icode,
  input  wordT  valA,
  input  wordT  valE,
  input  wordT  valP,
  output wordT  valM,
  output logic  dmemError
);
  localparam int idxW = $clog2(dmemWords);

  wordT            mem [dmemWords];
  wordT            memAddr;
  wordT            wrData;
  logic            memRead;
  logic            memWrite;
  logic [idxW-1:0] wordIdx;

  // pop and ret read the old stack pointer
  assign memAddr = (icode inside {icPopq, icRet}) ? valA : valE;

  // call pushes the return address
  assign wrData = (icode == icCall) ? valP : valA;

  assign memRead  = icode inside {icMrmovq, icPopq, icRet};
  assign memWrite = icode inside {icRmmovq, icPushq, icCall};

  assign wordIdx = memAddr[idxW+2:3];

  // misaligned or past the last word
  assign dmemError = (memRead || memWrite) &&
                     ((memAddr[2:0] != 3'b000) || (memAddr[63:3] >= 61'(dmemWords)));

  assign valM = (memRead && !dmemError) ? mem[wordIdx] : '0;

  always_ff @(posedge clk) begin
    if (run && memWrite && !dmemError) begin
      mem[wordIdx] <= wrData;
    end
  end

endmodule

`default_nettype wire

/* rtl/pcUpdate.sv */
`default_nettype none

module pcUpdate
  import y86Pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  icodeT icode,
  input  logic  cnd,
  input  wordT  valC,
  input  wordT  valM,
  input  wordT  valP,
  input  logic  instrValid,
  input  logic  imemError,
  input  logic  dmemError,
  output wordT  pc,
  output statT  stat,
  output logic  run
);
  statT nextStat;
  wordT nextPc;

  // error priority: fetch, decode, memory, then halt
  always_comb begin
    if (imemError) begin
      nextStat = statAdr;
    end else if (!instrValid) begin
      nextStat = statIns;
    end else if (dmemError) begin
      nextStat = statAdr;
    end else if (icode == icHalt) begin
      nextStat = statHlt;
    end else begin
      nextStat = statAok;
    end
  end

  // global commit enable for every state element
  assign run = !rst && (stat == statAok) && (nextStat == statAok);

  always_comb begin
    if (icode == icCall || (icode == icJxx && cnd)) begin
      nextPc = valC;
    end else if (icode == icRet) begin
      nextPc = valM;
    end else begin
      nextPc = valP;
    end
  end

  // stat is sticky, pc parks on the stopping instruction
  always_ff @(posedge clk) begin
    if (rst) begin
      pc   <= '0;
      stat <= statAok;
    end else if (stat == statAok) begin
      stat <= nextStat;
      if (run) begin
        pc <= nextPc;
      end
    end
  end

  assert property (@(posedge clk) disable iff (rst) stat != statAok |=> stat != statAok);

  assert property (@(posedge clk) disable iff (rst) stat != statAok |=> $stable(pc));

endmodule

`default_nettype wire

/* rtl/y86Seq.sv */
`default_nettype none

module y86Seq
  import y86Pkg::*;
#(
  parameter int imemBytes = 256,
  parameter int dmemWords = 64
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       progWe,
  input  wordT       progAddr,
  input  logic [7:0] progData,
  input  regIdT      dbgReg,
  output wordT       dbgValue,
  output wordT       pc,
  output statT       stat
);
  icodeT icode;
  ifunT  ifun;
  regIdT rA;
  regIdT rB;
  wordT  valC;
  wordT  valP;
  wordT  valA;
  wordT  valB;
  wordT  valE;
  wordT  valM;
  logic  cnd;
  logic  instrValid;
  logic  imemError;
  logic  dmemError;
  logic  run;

  // fetch, also owns the program load port
  fetchStage #(.imemBytes(imemBytes)) fetch_i (
    .clk, .rst, .progWe, .progAddr, .progData, .pc,
    .icode, .ifun, .rA, .rB, .valC, .valP, .instrValid, .imemError
  );

  // register file, read in decode and written back on the edge
  decodeWriteback decode_i (
    .clk, .run, .icode, .rA, .rB, .cnd, .valE, .valM, .dbgReg,
    .valA, .valB, .dbgValue
  );

  executeStage execute_i (
    .clk, .rst, .run, .icode, .ifun, .valA, .valB, .valC,
    .valE, .cnd
  );

  dataMemory #(.dmemWords(dmemWords)) memory_i (
    .clk, .run, .icode, .valA, .valE, .valP,
    .valM, .dmemError
  );

  // pc, status and the commit enable
  pcUpdate pcUpdate_i (
    .clk, .rst, .icode, .cnd, .valC, .valM, .valP,
    .instrValid, .imemError, .dmemError,
    .pc, .stat, .run
  );

endmodule

`default_nettype wire

/* tests/clockGen.sv */
`default_nettype none

module clockGen #(
  parameter int period = 10
) (
  output logic clk
);

  // free running, starts low
  initial begin
    clk = 1'b0;
    forever begin
      #(period / 2) clk = ~clk;
    end
  end

endmodule

`default_nettype wire

/* tests/y86SeqTb.sv */
`default_nettype none

module y86SeqTb
  import y86Pkg::*;
();
  localparam int imemBytes   = 256;
  localparam int dmemWords   = 64;
  localparam int resetCycles = 10;
  localparam int stopTimeout = 2000;
  localparam int frozenWait  = 5;
  localparam int driveDelay  = 1;

  logic       clk;
  logic       rst;
  logic       progWe;
  wordT       progAddr;
  logic [7:0] progData;
  regIdT      dbgReg;
  wordT       dbgValue;
  wordT       pc;
  statT       stat;

  // program image, one entry per byte, tagged with its program number
  int         byteProg [$];
  wordT       byteAddrQ [$];
  logic [7:0] byteDataQ [$];
  // expected registers per program
  int         regProg [$];
  regIdT      regIdQ [$];
  wordT       regValQ [$];
  // expected stat and pc, one entry per program
  statT       expStat [$];
  wordT       expPc [$];
  int         progCount;

  clockGen #(.period(10)) clock_i (.clk);

  y86Seq #(
    .imemBytes(imemBytes),
    .dmemWords(dmemWords)
  ) dut_i (
    .clk, .rst, .progWe, .progAddr, .progData, .dbgReg,
    .dbgValue, .pc, .stat
  );

  task automatic stopOnError();
    $display("*** FAILED ***");
    $fatal(1, "run stopped at the first error");
  endtask

  // tagged lines, '#' starts a comment up to the end of the line
  task automatic readPatterns();
    int         fd;
    int         n;
    int         ch;
    int         cnt;
    logic [7:0] tag;
    wordT       addr;
    logic [79:0] bits;
    regIdT      rid;
    wordT       val;
    statT       st;
    logic       atEnd;
    fd = $fopen("tests/programPatterns.hex", "r");
    if (fd == 0) begin
      $display("cannot open the pattern file tests/programPatterns.hex");
      stopOnError();
    end
    progCount = 0;
    atEnd = 1'b0;
    while (!atEnd) begin
      n = $fscanf(fd, " %c", tag);
      if (n != 1) begin
        atEnd = 1'b1;
      end else begin
        case (tag)
          "#": ;
          "P": begin
            n = $fscanf(fd, "%h %h %h", addr, cnt, bits);
            if (n != 3 || cnt < 1 || cnt > 10) begin
              $display("malformed program line in the pattern file");
              stopOnError();
            end
            // leftmost byte of the token goes to the lowest address
            for (int k = 0; k < cnt; k++) begin
              byteProg.push_back(progCount);
              byteAddrQ.push_back(addr + wordT'(k));
              byteDataQ.push_back(bits[8*(cnt-1-k) +: 8]);
            end
          end
          "E": begin
            n = $fscanf(fd, "%h %h", rid, val);
            regProg.push_back(progCount);
            regIdQ.push_back(rid);
            regValQ.push_back(val);
          end
          "S": begin
            n = $fscanf(fd, "%h", st);
            expStat.push_back(st);
          end
          "C": begin
            n = $fscanf(fd, "%h", val);
            expPc.push_back(val);
            // C closes the current program
            progCount++;
          end
          default: begin
            $display("unknown tag in the pattern file");
            stopOnError();
          end
        endcase
        // drop the rest of the line, trailing comments included
        ch = $fgetc(fd);
        while (ch != 10 && ch != -1) begin
          ch = $fgetc(fd);
        end
      end
    end
    $fclose(fd);
    if (progCount == 0 || expStat.size() != progCount) begin
      $display("pattern file holds no complete program or a program lacks its S line");
      stopOnError();
    end
  endtask

  // reset stays high for ten cycles or as long as the image takes
  task automatic loadAndReset(input int p);
    int cycles;
    cycles = 0;
    @(posedge clk);
    #driveDelay;
    rst = 1'b1;
    for (int i = 0; i < byteAddrQ.size(); i++) begin
      if (byteProg[i] == p) begin
        progWe   = 1'b1;
        progAddr = byteAddrQ[i];
        progData = byteDataQ[i];
        @(posedge clk);
        #driveDelay;
        cycles++;
      end
    end
    progWe   = 1'b0;
    progAddr = '0;
    progData = '0;
    while (cycles < resetCycles) begin
      @(posedge clk);
      #driveDelay;
      cycles++;
    end
    rst = 1'b0;
  endtask

  task automatic idleCycles(input int count);
    for (int i = 0; i < count; i++) begin
      @(posedge clk);
      #driveDelay;
    end
  endtask

  task automatic waitForStop();
    int n;
    n = 0;
    while (stat == statAok) begin
      if (n == stopTimeout) begin
        $display("timeout, the core was still running after %0d cycles", stopTimeout);
        stopOnError();
      end
      @(posedge clk);
      #driveDelay;
      n++;
    end
  endtask

  // stat, pc, then one debug read per expected register
  task automatic checkFinalState(input int p);
    assert (stat == expStat[p]) else begin
      $display("** Error at %0t: stat = %0d, expected %0d", $time, stat, expStat[p]);
      stopOnError();
    end
    assert (pc == expPc[p]) else begin
      $display("** Error at %0t: pc = 0x%h, expected 0x%h", $time, pc, expPc[p]);
      stopOnError();
    end
    for (int i = 0; i < regIdQ.size(); i++) begin
      if (regProg[i] == p) begin
        @(posedge clk);
        #driveDelay;
        dbgReg = regIdQ[i];
        #driveDelay;
        assert (dbgValue == regValQ[i]) else begin
          $display("** Error at %0t: dbgValue (reg %0d) = 0x%h, expected 0x%h",
                   $time, regIdQ[i], dbgValue, regValQ[i]);
          stopOnError();
        end
      end
    end
  endtask

  initial begin
    int idle;
    rst      = 1'b1;
    progWe   = 1'b0;
    progAddr = '0;
    progData = '0;
    dbgReg   = regNone;
    void'($urandom(56));
    readPatterns();
    for (int p = 0; p < progCount; p++) begin
      loadAndReset(p);
      // a few idle cycles before watching stat
      idle = $urandom % 4;
      idleCycles(idle);
      waitForStop();
      checkFinalState(p);
      // stopped core must stay frozen
      idleCycles(frozenWait);
      checkFinalState(p);
    end
    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* tests/programPatterns.hex */
# P <addr> <count> <bytes>  program bytes in memory order, all fields hex
# E <reg> <value> expected register, S <stat> expected status, C <pc> expected pc and end of program
# stat codes 1 hlt 2 adr 3 ins
P 000 a 30f40002000000000000  # irmovq $0x200, %rsp
P 00a a 30f00500000000000000  # irmovq $5, %rax
P 014 a 30f30300000000000000  # irmovq $3, %rbx
P 01e 2 2001                  # rrmovq %rax, %rcx
P 020 2 6031                  # addq %rbx, %rcx
P 022 2 2002                  # rrmovq %rax, %rdx
P 024 2 6132                  # subq %rbx, %rdx
P 026 2 2006                  # rrmovq %rax, %rsi
P 028 2 6236                  # andq %rbx, %rsi
P 02a 2 2007                  # rrmovq %rax, %rdi
P 02c 2 6337                  # xorq %rbx, %rdi
P 02e a 30f50001000000000000  # irmovq $0x100, %rbp
P 038 a 40150800000000000000  # rmmovq %rcx, 8(%rbp)
P 042 a 50850800000000000000  # mrmovq 8(%rbp), %r8
P 04c 2 a02f                  # pushq %rdx
P 04e 2 b09f                  # popq %r9
P 050 a 30fa0900000000000000  # irmovq $9, %r10
P 05a 2 210a                  # cmovle %rax, %r10 not taken
P 05c 2 263b                  # cmovg %rbx, %r11 taken
P 05e a 30fc0100000000000000  # irmovq $1, %r12
P 068 a 30fd0700000000000000  # irmovq $7, %r13
P 072 2 613c                  # subq %rbx, %r12
P 074 9 748700000000000000    # jne 0x87
P 07d a 30fdad0b000000000000  # irmovq $0xbad, %r13 skipped
P 087 9 80a000000000000000    # call 0xa0
P 090 1 00                    # halt
P 0a0 a 30fe3412000000000000  # irmovq $0x1234, %r14
P 0aa 1 90                    # ret
E 0 5
E 1 8
E 2 2
E 3 3
E 4 200
E 5 100
E 6 1
E 7 6
E 8 8
E 9 2
E a 9
E b 3
E c fffffffffffffffe
E d 7
E e 1234
S 1
C 090
# second program, the load address 0x13 is not 8-byte aligned
P 000 a 30f05500000000000000  # irmovq $0x55, %rax
P 00a a 30f11300000000000000  # irmovq $0x13, %rcx
P 014 a 50010000000000000000  # mrmovq 0(%rcx), %rax
P 01e 1 00                    # halt
E 0 55
E 1 13
S 2
C 014

/* flist.f */
rtl/y86Pkg.sv
rtl/fetchStage.sv
rtl/decodeWriteback.sv
rtl/executeStage.sv
rtl/dataMemory.sv
rtl/pcUpdate.sv
rtl/y86Seq.sv
tests/clockGen.sv
tests/y86SeqTb.sv

/* Makefile */
# Verilator build and run of the Y86-64 SEQ testbench

VERILATOR ?= verilator
TOP       ?= y86SeqTb
FLAGS     ?= -j 0

FLIST   := flist.f
OBJ_DIR := obj_dir
SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FLIST)
	$(VERILATOR) --binary --assert $(FLAGS) --top-module $(TOP) -f $(FLIST) -o V$(TOP)

# exit status of the simulator is the pass or fail result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
